// File: cart_stim.txt
# op mapper addr data cnt exp_sel exp_waddr exp_flags(rom,sram) exp_rbyte, all hex
# op 0 read 1 read cs high 2 write 6 readback 3 load 4 mcu wr 5 mcu rd 7 held-bus wr
0 0 C01234 00 0 E 0091A 2 00
0 0 F5ABCD 00 0 D AD5E6 2 00
0 0 206000 00 0 7 00000 1 00
1 0 A07FFF 00 0 7 00FFF 1 00
0 0 001000 00 0 F 00000 0 00
2 0 206002 33 0 7 00001 1 00
6 0 206002 00 0 7 00001 1 33
0 1 700000 00 0 7 00000 3 00
0 1 7D1235 00 0 7 0091A 3 00
0 1 7E1234 00 0 D F891A 2 00
1 1 808000 00 0 F 00000 2 00
0 5 C01234 00 0 F 00000 0 00
2 5 206000 5A 0 F 00000 0 00
3 0 200010 00 0 F 00000 0 00
4 0 200010 11 0 D 00008 0 00
4 0 200011 22 0 D 00008 0 00
4 0 200012 33 0 D 00009 0 00
3 0 200010 00 0 F 00000 0 00
5 0 200010 00 0 D 00008 0 11
5 0 200011 00 0 D 00008 0 22
5 0 200012 00 0 D 00009 0 33
6 0 600010 00 0 D 00008 2 11
6 0 600011 00 0 D 00008 2 22
6 0 600012 00 0 D 00009 2 33
3 0 000100 00 0 F 00000 0 00
7 0 000100 5C 4 E 00080 0 00
3 0 000100 00 0 F 00000 0 00
5 0 000100 00 0 E 00080 0 5C

// File: sim.f
cart_pkg.sv
address_map.sv
mcu_addr_reg.sv
bus_phase.sv
sram_port.sv
cart_top.sv
tb_cart.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module tb_cart -f sim.f -o vtb_cart
	@out="$$(./obj_dir/vtb_cart)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module tb_cart -f sim.f

clean:
	rm -rf obj_dir

// File: tb_cart.sv
`timescale 1ns/1ns

module tb_cart import cart_pkg::*; ();

   localparam int SAVERAM_CHIP = 3;
   localparam int MAX_REC      = 64;

   // One line of the stimulus file
   typedef struct packed {
      logic [3:0]  op;      // 0-2,6 console, 3 load, 4/5 MCU, 7 held bus
      logic [2:0]  mapper;
      logic [23:0] addr;    // Bus address, or expected MCU address
      logic [7:0]  data;
      logic [7:0]  cnt;     // Cycles the console holds the bus
      logic [3:0]  sel;
      logic [19:0] waddr;
      logic [1:0]  flags;   // {is_rom, is_saveram}
      logic [7:0]  rbyte;
   } stim_t;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic [23:0] snes_addr, mcu_addr_in;
   logic snes_cs, snes_rd, snes_wr, addr_write, mcu_req, mcu_we;
   logic [7:0] snes_wdata, mcu_wdata, snes_rdata, mcu_rdata;
   logic is_rom, is_saveram, mcu_done, mem_we_n;
   mapper_e mapper;
   logic [19:0] mem_addr;
   logic [3:0] mem_sel_n;
   logic [1:0] mem_be_n;
   logic [15:0] mem_wdata, mem_rdata;
   logic [15:0] sram [4][256];   // Four chips, low 8 word address bits

   stim_t recs [MAX_REC];
   int n_rec = 0;
   int n_pass = 0;
   int n_fail = 0;
   int test_err = 0;
   int seed = 68913;

   always #10 clk = ~clk;   // 20 ns period

   cart_top #(.SAVERAM_CHIP(SAVERAM_CHIP)) u_dut (
      .clk(clk), .rst(rst), .snes_addr(snes_addr), .snes_cs(snes_cs), .snes_rd(snes_rd),
      .snes_wr(snes_wr), .snes_wdata(snes_wdata), .snes_rdata(snes_rdata),
      .is_rom(is_rom), .is_saveram(is_saveram), .mapper(mapper), .mcu_addr_in(mcu_addr_in),
      .addr_write(addr_write), .mcu_req(mcu_req), .mcu_we(mcu_we), .mcu_wdata(mcu_wdata),
      .mcu_rdata(mcu_rdata), .mcu_done(mcu_done), .mem_addr(mem_addr),
      .mem_sel_n(mem_sel_n), .mem_be_n(mem_be_n), .mem_we_n(mem_we_n),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
   );

   //////////////////////////////////////////////////////////////////////
   // SRAM chip model
   //////////////////////////////////////////////////////////////////////

   initial begin
      for (int c = 0; c < 4; c++)
         for (int i = 0; i < 256; i++)
            sram[c][i] = {4'(c), 4'h5, 8'(i)};   // Chip and word in every cell
   end

   always @(posedge clk) begin
      for (int c = 0; c < 4; c++) begin
         if (!mem_sel_n[c] && !mem_we_n) begin
            if (!mem_be_n[0])
               sram[c][mem_addr[7:0]][7:0] <= mem_wdata[7:0];
            if (!mem_be_n[1])
               sram[c][mem_addr[7:0]][15:8] <= mem_wdata[15:8];  // High lane
         end
      end
   end

   always_comb begin
      mem_rdata = 16'hFFFF;   // Floating bus
      for (int c = 0; c < 4; c++)
         if (!mem_sel_n[c])
            mem_rdata = sram[c][mem_addr[7:0]];
   end

   //////////////////////////////////////////////////////////////////////
   // Drive and check helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check_val(input string name, input logic [23:0] exp, input logic [23:0] act);
      assert (exp === act)
      else begin
         $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
         test_err++;
      end
   endtask

   task automatic at_edge();
      @(posedge clk);
      #2;   // Drive point after the edge
   endtask

   task automatic idle_inputs();
      snes_addr   = 24'h000000;   // Decodes to nothing in every mapper
      snes_cs     = 1'b1;
      snes_rd     = 1'b0;
      snes_wr     = 1'b1;         // Filler write with junk data
      snes_wdata  = 8'($random(seed));
      addr_write  = 1'b0;
      mcu_addr_in = 24'h000000;
      mcu_req     = 1'b0;
      mcu_we      = 1'b0;
      mcu_wdata   = 8'h00;
   endtask

   task automatic snes_access(input stim_t r);
      snes_addr  = r.addr;
      snes_cs    = (r.op == 4'd1);   // Op 1 keeps the cart pin high
      snes_rd    = (r.op != 4'd2);
      snes_wr    = (r.op == 4'd2);
      snes_wdata = r.data;
      #5;
      check_val("is_rom", 24'(r.flags[1]), 24'(is_rom));
      check_val("is_saveram", 24'(r.flags[0]), 24'(is_saveram));
      at_edge();                     // Request now registered toward the chips
      check_val("mem_sel_n", 24'(r.sel), 24'(mem_sel_n));
      if (r.sel != 4'hF)
         check_val("mem_addr", 24'(r.waddr), 24'(mem_addr));
      if (r.op == 4'd2)
         check_val("mem_we_n", 24'(!r.flags[0]), 24'(mem_we_n));  // Save RAM only
      if (r.op == 4'd6)
         check_val("snes_rdata", 24'(r.rbyte), 24'(snes_rdata));
      idle_inputs();
   endtask

   task automatic load_mcu_addr(input stim_t r);
      addr_write  = 1'b1;
      mcu_addr_in = r.addr;
      at_edge();
      idle_inputs();
   endtask

   task automatic mcu_access(input stim_t r);
      int hold;
      int n;
      hold      = (r.op == 4'd7) ? int'(r.cnt) : 0;
      mcu_req   = 1'b1;
      mcu_we    = (r.op != 4'd5);
      mcu_wdata = r.data;
      if (hold > 0) begin
         snes_cs = 1'b0;   // Console owns the bus
         snes_wr = 1'b0;
         snes_rd = 1'b1;
      end
      for (int k = 0; k < hold; k++) begin
         at_edge();
         mcu_req = 1'b0;
         check_val("mcu_done", 24'd0, 24'(mcu_done));
      end
      snes_cs = 1'b1;
      snes_rd = 1'b0;
      at_edge();
      mcu_req = 1'b0;
      n = hold + 1;
      while (!mcu_done && n < hold + 8) begin
         at_edge();
         n++;
      end
      assert (mcu_done)
      else begin
         $display("mcu_done never came after the MCU request at t=%0t", $time);
         test_err++;
      end
      if (mcu_done) begin
         check_val("mcu_latency", 24'd2, 24'(n - hold));
         check_val("mem_sel_n", 24'(r.sel), 24'(mem_sel_n));
         check_val("mem_addr", 24'(r.waddr), 24'(mem_addr));
         check_val("mem_be_n", r.addr[0] ? 24'd1 : 24'd2, 24'(mem_be_n));  // Odd is high lane
         check_val("mem_we_n", 24'(r.op == 4'd5), 24'(mem_we_n));
         if (r.op == 4'd5)
            check_val("mcu_rdata", 24'(r.rbyte), 24'(mcu_rdata));
         else
            check_val("mem_wdata", 24'({r.data, r.data}), 24'(mem_wdata));
         at_edge();
         check_val("mcu_done", 24'd0, 24'(mcu_done));   // One pulse only
      end
      idle_inputs();
   endtask

   task automatic run_record(input stim_t r);
      test_err = 0;
      mapper   = mapper_e'(r.mapper);
      case (r.op)
         4'd0, 4'd1, 4'd2, 4'd6: snes_access(r);
         4'd3:                   load_mcu_addr(r);
         4'd4, 4'd5, 4'd7:       mcu_access(r);
         default: begin
            $display("record op %0d is not a known operation", r.op);
            test_err++;
         end
      endcase
   endtask

   task automatic load_records(input int fd);
      string line;
      stim_t r;
      int op, mp, ad, dt, ct, sl, wa, fl, rb;
      while (!$feof(fd) && n_rec < MAX_REC) begin
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#" &&
             $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                     op, mp, ad, dt, ct, sl, wa, fl, rb) == 9) begin
            r = '{op: 4'(op), mapper: 3'(mp), addr: 24'(ad), data: 8'(dt), cnt: 8'(ct),
                  sel: 4'(sl), waddr: 20'(wa), flags: 2'(fl), rbyte: 8'(rb)};
            recs[n_rec] = r;
            n_rec++;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin : main
      int fd;
      idle_inputs();
      mapper = map_hirom;
      fd = $fopen("cart_stim.txt", "r");
      if (fd == 0) begin
         $display("stimulus file cart_stim.txt could not be opened");
      end else begin
         load_records(fd);
         $fclose(fd);
         repeat (5) @(posedge clk);
         #2 rst = 1'b0;
         for (int i = 0; i < n_rec; i++) begin
            at_edge();
            run_record(recs[i]);
            if (test_err == 0)
               n_pass++;
            else
               n_fail++;
            $display("test %0d op %0d addr %h %s", i, recs[i].op, recs[i].addr,
                     (test_err == 0) ? "ok" : "failed");
         end
         $display("tests %0d passed %0d failed %0d", n_rec, n_pass, n_fail);
      end
      if (n_rec > 0 && n_fail == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : watchdog
      wait (n_rec > 0);
      repeat (n_rec * 40 + 200) @(posedge clk);   // Worst case per record plus margin
      $display("watchdog expired before the tests finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: cart_top.sv
`timescale 1ns/1ns

module cart_top import cart_pkg::*; #(
   parameter int SAVERAM_CHIP = 3
) (
   input  logic        clk,
   input  logic        rst,
   // Console side
   input  logic [23:0] snes_addr,
   input  logic        snes_cs,     // Active low
   input  logic        snes_rd,
   input  logic        snes_wr,
   input  logic [7:0]  snes_wdata,
   output logic [7:0]  snes_rdata,
   output logic        is_rom,
   output logic        is_saveram,
   // MCU side
   input  mapper_e     mapper,
   input  logic [23:0] mcu_addr_in,
   input  logic        addr_write,
   input  logic        mcu_req,
   input  logic        mcu_we,
   input  logic [7:0]  mcu_wdata,
   output logic [7:0]  mcu_rdata,
   output logic        mcu_done,
   // SRAM chips
   output logic [19:0] mem_addr,
   output logic [3:0]  mem_sel_n,
   output logic [1:0]  mem_be_n,
   output logic        mem_we_n,
   output logic [15:0] mem_wdata,
   input  logic [15:0] mem_rdata
);

   phase_e      phase;
   logic        mcu_step;
   logic [23:0] mcu_addr;
   bus_req_t    snes_bus;
   bus_req_t    mcu_bus;
   bus_req_t    sel_bus;   // Request for the current phase
   mem_req_t    map_req;
   mem_req_t    port_req;  // Decoded request plus write byte
   logic [7:0]  rdata;

   //////////////////////////////////////////////////////////////////////
   // Request sources
   //////////////////////////////////////////////////////////////////////

   assign snes_bus = '{addr: snes_addr, we: snes_wr, re: snes_rd, valid: 1'b1}; // Decoder qualifies
   assign mcu_bus  = '{addr: mcu_addr, we: mcu_we, re: ~mcu_we, valid: phase == phase_mcu};
   assign sel_bus  = (phase == phase_mcu) ? mcu_bus : snes_bus;

   always_comb begin
      port_req       = map_req;
      port_req.wdata = (phase == phase_mcu) ? mcu_wdata : snes_wdata;
   end

   //////////////////////////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////////////////////////

   bus_phase u_phase (
      .clk(clk), .rst(rst), .snes_cs(snes_cs), .mcu_req(mcu_req),
      .phase(phase), .mcu_step(mcu_step), .mcu_done(mcu_done)
   );

   mcu_addr_reg u_mcu_addr (
      .clk(clk), .rst(rst), .addr_write(addr_write), .mcu_addr_in(mcu_addr_in),
      .mcu_step(mcu_step), .mcu_addr(mcu_addr)
   );

   address_map #(.SAVERAM_CHIP(SAVERAM_CHIP)) u_map (
      .mapper(mapper), .phase(phase), .req(sel_bus), .snes_cs(snes_cs),
      .mreq(map_req), .is_rom(is_rom), .is_saveram(is_saveram)
   );

   sram_port u_port (
      .clk(clk), .rst(rst), .mreq(port_req),
      .mem_addr(mem_addr), .mem_sel_n(mem_sel_n), .mem_be_n(mem_be_n),
      .mem_we_n(mem_we_n), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
      .rdata(rdata)
   );

   assign snes_rdata = rdata;  // Both sides share one read path
   assign mcu_rdata  = rdata;

endmodule

// File: sram_port.sv
`timescale 1ns/1ns

module sram_port import cart_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  mem_req_t    mreq,
   output logic [19:0] mem_addr,
   output logic [3:0]  mem_sel_n,  // Chip selects, active low
   output logic [1:0]  mem_be_n,   // Bit 1 is high byte
   output logic        mem_we_n,
   output logic [15:0] mem_wdata,
   input  logic [15:0] mem_rdata,
   output logic [7:0]  rdata
);

   logic active;   // Some chip selected
   logic lane_hi;  // Registered byte lane for read steering

   assign active = (mreq.sel_n != 4'hF);

   //////////////////////////////////////////////////////////////////////
   // Control registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_sel_n <= 4'hF;
         mem_we_n  <= 1'b1;
         mem_be_n  <= 2'b11;
      end else begin
         mem_sel_n <= mreq.sel_n;
         mem_we_n  <= ~(mreq.we & active);   // No write without a chip
         if (!active)
            mem_be_n <= 2'b11;
         else if (mreq.byte_hi)
            mem_be_n <= 2'b01;               // Upper lane
         else
            mem_be_n <= 2'b10;               // Lower lane
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Address and data path
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      mem_addr  <= mreq.word_addr;
      mem_wdata <= {mreq.wdata, mreq.wdata}; // Same byte on both halves
      lane_hi   <= mreq.byte_hi;
   end

   // Pick the byte back out of the word
   assign rdata = lane_hi ? mem_rdata[15:8] : mem_rdata[7:0];

   // A write strobe must always land on a chip
   assert property (@(posedge clk) disable iff (rst) !mem_we_n |-> mem_sel_n != 4'hF)
      else $error("sram_port: write with no chip selected");

endmodule

// File: bus_phase.sv
`timescale 1ns/1ns

module bus_phase import cart_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   snes_cs,   // Low while console owns the cart
   input  logic   mcu_req,   // Access request pulse
   output phase_e phase,
   output logic   mcu_step,  // Bump MCU address
   output logic   mcu_done   // Result ready pulse
);

   logic pending;  // Request waiting for a free bus

   //////////////////////////////////////////////////////////////////////
   // Phase sequencer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         phase    <= phase_snes;
         pending  <= 1'b0;
         mcu_done <= 1'b0;
      end else begin
         mcu_done <= (phase == phase_mcu); // Data comes back one cycle after slot
         case (phase)
            phase_snes: begin
               if (snes_cs && (pending || mcu_req)) begin
                  phase   <= phase_mcu;  // Bus idle, grant slot
                  pending <= 1'b0;
               end else if (mcu_req) begin
                  pending <= 1'b1;       // Hold until cart pin released
               end
            end
            phase_mcu: begin
               phase   <= phase_snes;    // Single cycle slot only
               pending <= mcu_req;
            end
            default: phase <= phase_snes;
         endcase
      end
   end

   assign mcu_step = (phase == phase_mcu);

   // MCU slot never stretches into a second cycle
   assert property (@(posedge clk) disable iff (rst)
                    phase == phase_mcu |=> phase == phase_snes)
      else $error("bus_phase: MCU phase longer than one cycle");

endmodule

// File: mcu_addr_reg.sv
`timescale 1ns/1ns

module mcu_addr_reg (
   input  logic        clk,
   input  logic        rst,
   input  logic        addr_write,  // Load strobe from MCU
   input  logic [23:0] mcu_addr_in,
   input  logic        mcu_step,    // One MCU access done
   output logic [23:0] mcu_addr
);

   //////////////////////////////////////////////////////////////////////
   // Address counter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         mcu_addr <= '0;
      end else if (addr_write) begin
         mcu_addr <= mcu_addr_in;        // Load beats step
      end else if (mcu_step) begin
         mcu_addr <= mcu_addr + 24'd1;   // Next byte
      end
   end

   // Loading mid-access would drop the increment, MCU must wait for done
   assert property (@(posedge clk) disable iff (rst) !(addr_write && mcu_step))
      else $error("mcu_addr_reg: addr_write during MCU access");

endmodule

// File: address_map.sv
`timescale 1ns/1ns

module address_map import cart_pkg::*; #(
   parameter int SAVERAM_CHIP = 3 // Chip holding save RAM
) (
   input  mapper_e  mapper,
   input  phase_e   phase,
   input  bus_req_t req,
   input  logic     snes_cs,    // Cart pin, active low
   output mem_req_t mreq,
   output logic     is_rom,
   output logic     is_saveram
);

   // Fixed select for save RAM accesses
   localparam logic [3:0] SAVERAM_SEL_N = ~(4'b0001 << SAVERAM_CHIP);

   logic        in_mcu;
   logic        sram_hit;   // Save RAM window hit
   logic        rom_hit;    // ROM area hit
   logic        hit;        // Access goes out to a chip
   logic [22:0] snes_full;  // Console address folded into chip space
   logic [22:0] full_addr;
   logic [3:0]  sel_n;

   assign in_mcu = (phase == phase_mcu);

   //////////////////////////////////////////////////////////////////////
   // Mapper decode of the console address
   //////////////////////////////////////////////////////////////////////

   always_comb begin : decode
      sram_hit  = 1'b0;
      rom_hit   = 1'b0;
      snes_full = '0;
      case (mapper)
         map_hirom: begin
            // Banks 20-3f/a0-bf, 6000-7fff, cart pin ignored
            sram_hit = ~req.addr[22] & req.addr[21] & ~req.addr[15]
                       & (&req.addr[14:13]);
            rom_hit  = req.addr[22] | req.addr[15];
            if (sram_hit)
               snes_full = {8'h00, req.addr[14:0] - 15'h6000}; // Window base to 0
            else
               snes_full = {1'b0, req.addr[21:0]};              // Mirror bit 22 away
         end
         map_lorom: begin
            // Banks 70-7d/f0-fd, lower half
            sram_hit = (&req.addr[22:20]) & (req.addr[19:16] < 4'hE)
                       & ~req.addr[15] & ~snes_cs;
            rom_hit  = req.addr[22] | req.addr[15];
            if (sram_hit)
               snes_full = {8'h00, req.addr[14:0]};
            else
               snes_full = {1'b0, req.addr[22:16], req.addr[14:0]}; // Drop A15
         end
         default: ; // Unmapped, nothing hits
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Request assembly
   //////////////////////////////////////////////////////////////////////

   assign full_addr = in_mcu ? req.addr[22:0] : snes_full; // MCU address goes raw

   // ROM only with cart pin low, save RAM decides on its own
   assign hit = in_mcu ? req.valid
                       : req.valid & (sram_hit | (rom_hit & ~snes_cs));

   assign sel_n = !hit                 ? 4'hF :
                  (!in_mcu && sram_hit) ? SAVERAM_SEL_N :
                  ~(4'b0001 << full_addr[22:21]);   // Top two bits pick chip

   assign mreq.word_addr = full_addr[20:1];
   assign mreq.sel_n     = sel_n;
   assign mreq.byte_hi   = full_addr[0];
   // Console may only write save RAM, read wins over write
   assign mreq.we        = hit & req.we & ~req.re & (in_mcu | sram_hit);
   assign mreq.wdata     = 8'h00;   // Data merged at top level

   assign is_rom     = ~in_mcu & rom_hit;
   assign is_saveram = ~in_mcu & sram_hit;

   // At most one chip ever selected
   always_comb begin
      assert ($onehot0(~sel_n))
         else $error("address_map: sel_n %b not one-hot", sel_n);
   end

endmodule

// File: cart_pkg.sv
package cart_pkg;

   //////////////////////////////////////////////////////////////////////
   // Mapper and bus phase codes
   //////////////////////////////////////////////////////////////////////

   // Mapper code from the MCU, anything else is unmapped
   typedef enum logic [2:0] {
      map_hirom = 3'd0,   // Banks 40-7f/c0-ff plus upper halves
      map_lorom = 3'd1    // 32K pages, bank bits packed down
   } mapper_e;

   // Who owns the address bus this cycle
   typedef enum logic {
      phase_snes = 1'b0,
      phase_mcu  = 1'b1
   } phase_e;

   //////////////////////////////////////////////////////////////////////
   // Request bundles
   //////////////////////////////////////////////////////////////////////

   // Raw bus request, console or MCU side
   typedef struct packed {
      logic [23:0] addr;  // 24-bit bus address
      logic        we;    // Write
      logic        re;    // Read
      logic        valid; // Source presents an access
   } bus_req_t;

   // Decoded access toward the SRAM chips
   typedef struct packed {
      logic [19:0] word_addr; // 16-bit word index within a chip
      logic [3:0]  sel_n;     // One-hot chip select, active low
      logic        byte_hi;   // High byte lane
      logic        we;        // Write enable, active high
      logic [7:0]  wdata;     // Byte to write
   } mem_req_t;

endpackage
